// ==== compile.f ====
source/boot_pkg.sv
source/boot_fsm.sv
source/fuse_intake.sv
source/fuse_bank.sv
source/fuse_boot_top.sv
sim/fuse_boot_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# builds the fuse boot testbench with Verilator, runs it and decides pass or fail from the log

cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

rm -rf obj_dir "$BUILD_LOG" "$SIM_LOG"

verilator --binary --timing --assert -j 0 --top-module fuse_boot_tb -f compile.f \
    > "$BUILD_LOG" 2>&1 || { cat "$BUILD_LOG"; echo "build failed"; exit 1; }

./obj_dir/Vfuse_boot_tb > "$SIM_LOG" 2>&1
cat "$SIM_LOG"

grep -qx "Done: no errors" "$SIM_LOG" && { echo "simulation passed"; exit 0; } \
    || { echo "simulation failed"; exit 1; }

// ==== sim/fuse_boot_tb.sv ====
// testbench for fuse_boot_top at its default sizes; it stops at the first failed check and needs a timing-capable simulator
`default_nettype none

module fuse_boot_tb;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int FUSE_WORDS   = boot_pkg::DEFAULT_FUSE_WORDS;
    localparam int CREDITS      = boot_pkg::DEFAULT_CREDITS;
    localparam int ADDR_W       = $clog2(FUSE_WORDS);
    localparam int DATA_W       = boot_pkg::FUSE_DATA_W;
    localparam int CLK_PERIOD   = 20;
    localparam int RESET_CYCLES = 5;

    // number of commands in each phase of the run
    localparam int N_PRE    = 4;
    localparam int N_RANDOM = 40;
    localparam int N_LATE   = 5;
    localparam int N_CMDS   = N_PRE + N_RANDOM + 1 + N_LATE;

    // the run gets twenty cycles per command plus a fixed margin for reset and read-back
    localparam int WATCHDOG_CYCLES = 20 * N_CMDS + 200;

    logic                     clk;
    logic                     cptra_rst_b;
    logic                     cptra_pwrgood;
    logic                     cmd_valid;
    boot_pkg::fuse_op_e       cmd_op;
    logic [ADDR_W-1:0]        cmd_addr;
    logic [DATA_W-1:0]        cmd_data;
    logic                     credit_return;
    logic                     ready_for_fuses;
    logic                     uc_rst_b;
    logic [ADDR_W-1:0]        rd_addr;
    logic [DATA_W-1:0]        rd_data;

    // boot state taken from inside the DUT so it shows by name
    boot_pkg::boot_fsm_state_e fsm_state;

    // stimulus source, stepped once for every bit that is used
    logic [31:0] lfsr_q = 32'h3da3_fa77;

    // commands sent and credit pulses seen
    // the sender holds CREDITS - (sent - returns) credits at any time
    int sent    = 0;
    int returns = 0;

    // reference model of the fuse bank and of the boot machine's ready flag
    logic [DATA_W-1:0] exp_val [FUSE_WORDS];
    logic              exp_wr  [FUSE_WORDS];
    logic              model_ready;

    // ready_for_fuses one cycle back
    // since_fall counts the cycles since ready fell and stays at -1 until then
    logic prev_ready = 1'b0;
    int   since_fall = -1;

    fuse_boot_top dut0 (
        .clk             (clk),
        .cptra_rst_b     (cptra_rst_b),
        .cptra_pwrgood   (cptra_pwrgood),
        .cmd_valid       (cmd_valid),
        .cmd_op          (cmd_op),
        .cmd_addr        (cmd_addr),
        .cmd_data        (cmd_data),
        .credit_return   (credit_return),
        .ready_for_fuses (ready_for_fuses),
        .uc_rst_b        (uc_rst_b),
        .rd_addr         (rd_addr),
        .rd_data         (rd_data)
    );

    assign fsm_state = dut0.fsm0.state_q;

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // Fibonacci LFSR with taps 32, 22, 2 and 1
    // each feedback bit is one output bit
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        logic        fb;
        v = '0;
        for (int i = 0; i < n; i++) begin
            fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
            lfsr_q = {lfsr_q[30:0], fb};
            v      = {v[30:0], fb};
        end
        return v;
    endfunction

    task automatic stop_on_failure();
        $display("Done: errors found");
        $fatal(1, "simulation stopped at the first failure");
    endtask

    task automatic check_eq(input string name, input logic [31:0] expected,
                            input logic [31:0] actual);
        assert (actual === expected) else begin
            $display("[ERROR] t=%0t %s expected %h actual %h", $time, name, expected, actual);
            stop_on_failure();
        end
    endtask

    // each credit_return pulse lasts one cycle and is counted at the rising edge that ends it
    always @(posedge clk) begin
        if (cptra_rst_b) begin
            if (credit_return) begin
                returns++;
            end
            assert (returns <= sent) else begin
                $display("[ERROR] t=%0t %0d credit returns but only %0d commands sent",
                         $time, returns, sent);
                stop_on_failure();
            end
        end
    end

    // uc_rst_b stays low while loading and rises exactly two cycles after ready falls
    always @(negedge clk) begin
        if (cptra_rst_b) begin
            if (prev_ready && !ready_for_fuses) begin
                since_fall = 0;
            end else if (since_fall >= 0) begin
                since_fall++;
            end
            // the done state is terminal, so ready never comes back
            if (since_fall >= 0) begin
                check_eq("ready_for_fuses", 32'(1'b0), 32'(ready_for_fuses));
            end
            check_eq("uc_rst_b", 32'(since_fall >= 2), 32'(uc_rst_b));
            prev_ready = ready_for_fuses;
        end
    end

    // called at a falling edge; waits for a credit, drives for one cycle
    task automatic send_cmd(input boot_pkg::fuse_op_e op, input logic [ADDR_W-1:0] addr,
                            input logic [DATA_W-1:0] data);
        while (sent - returns >= CREDITS) begin
            @(negedge clk);
        end
        cmd_valid = 1'b1;
        cmd_op    = op;
        cmd_addr  = addr;
        cmd_data  = data;
        sent++;
        // first write to a word during loading wins, everything else is dropped
        if (model_ready && op == boot_pkg::FUSE_OP_WRITE && !exp_wr[addr]) begin
            exp_val[addr] = data;
            exp_wr[addr]  = 1'b1;
        end
        if (op == boot_pkg::FUSE_OP_DONE) begin
            model_ready = 1'b0;
        end
        @(negedge clk);
        cmd_valid = 1'b0;
    endtask

    task automatic send_random_write();
        logic [ADDR_W-1:0] addr;
        logic [DATA_W-1:0] data;
        int                gap;
        addr = ADDR_W'(take_bits(ADDR_W));
        data = take_bits(DATA_W);
        send_cmd(boot_pkg::FUSE_OP_WRITE, addr, data);
        gap = int'(take_bits(2));
        repeat (gap) @(negedge clk);
    endtask

    // waits until every credit is back, then idles a few cycles so a stray pulse shows up
    task automatic drain_queue();
        while (returns != sent) begin
            @(negedge clk);
        end
        repeat (3) @(negedge clk);
    endtask

    task automatic read_back_all();
        for (int a = 0; a < FUSE_WORDS; a++) begin
            rd_addr = ADDR_W'(a);
            @(negedge clk);
            check_eq($sformatf("rd_data[%0d]", a), exp_val[a], rd_data);
        end
    endtask

    initial begin
        cptra_rst_b   = 1'b0;
        cptra_pwrgood = 1'b0;
        cmd_valid     = 1'b0;
        cmd_op        = boot_pkg::FUSE_OP_WRITE;
        cmd_addr      = '0;
        cmd_data      = '0;
        rd_addr       = '0;
        model_ready   = 1'b0;
        for (int a = 0; a < FUSE_WORDS; a++) begin
            exp_val[a] = '0;
            exp_wr[a]  = 1'b0;
        end
        repeat (RESET_CYCLES) @(negedge clk);
        cptra_rst_b = 1'b1;

        // quiet state out of reset
        repeat (2) @(negedge clk);
        check_eq("ready_for_fuses", 32'(1'b0), 32'(ready_for_fuses));
        check_eq("credit_return", 32'(1'b0), 32'(credit_return));
        check_eq("fsm_state", 32'(boot_pkg::BOOT_IDLE), 32'(fsm_state));

        // writes before power-good are popped and credited but not stored
        for (int i = 0; i < N_PRE; i++) begin
            send_random_write();
        end
        drain_queue();
        check_eq("ready_for_fuses", 32'(1'b0), 32'(ready_for_fuses));
        read_back_all();

        cptra_pwrgood = 1'b1;
        model_ready   = 1'b1;
        @(negedge clk);
        check_eq("ready_for_fuses", 32'(model_ready), 32'(ready_for_fuses));
        check_eq("fsm_state", 32'(boot_pkg::BOOT_FUSE), 32'(fsm_state));

        // forty writes over sixteen words, so some addresses repeat
        for (int i = 0; i < N_RANDOM; i++) begin
            send_random_write();
        end
        send_cmd(boot_pkg::FUSE_OP_DONE, ADDR_W'(take_bits(ADDR_W)), take_bits(DATA_W));
        while (!uc_rst_b) begin
            @(negedge clk);
        end
        check_eq("ready_for_fuses", 32'(model_ready), 32'(ready_for_fuses));
        check_eq("fsm_state", 32'(boot_pkg::BOOT_DONE), 32'(fsm_state));

        // late writes must come back as credits and change nothing
        for (int i = 0; i < N_LATE; i++) begin
            send_random_write();
        end
        drain_queue();
        read_back_all();
        check_eq("uc_rst_b", 32'(1'b1), 32'(uc_rst_b));

        $display("Done: no errors");
        $finish;
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("[ERROR] t=%0t watchdog expired before the test sequence finished", $time);
        stop_on_failure();
    end

endmodule

`default_nettype wire

// ==== source/fuse_boot_top.sv ====
// boot and fuse loading top; the SoC must honour the credit protocol and FUSE_WORDS must be a power of two
`default_nettype none

module fuse_boot_top #(
    parameter int unsigned FUSE_WORDS = boot_pkg::DEFAULT_FUSE_WORDS,
    parameter int unsigned CREDITS    = boot_pkg::DEFAULT_CREDITS
) (
    input  logic                                clk,
    input  logic                                cptra_rst_b,
    input  logic                                cptra_pwrgood,
    input  logic                                cmd_valid,
    input  boot_pkg::fuse_op_e                  cmd_op,
    input  logic [$clog2(FUSE_WORDS)-1:0]       cmd_addr,
    input  logic [boot_pkg::FUSE_DATA_W-1:0]    cmd_data,
    output logic                                credit_return,
    output logic                                ready_for_fuses,
    output logic                                uc_rst_b,
    input  logic [$clog2(FUSE_WORDS)-1:0]       rd_addr,
    output logic [boot_pkg::FUSE_DATA_W-1:0]    rd_data
);

    // address width shared by the command and read ports
    localparam int unsigned ADDR_W = $clog2(FUSE_WORDS);

    // queue head as seen by the fuse bank
    logic                             pop_valid;
    boot_pkg::fuse_op_e               pop_op;
    logic [ADDR_W-1:0]                pop_addr;
    logic [boot_pkg::FUSE_DATA_W-1:0] pop_data;

    // sticky end of fuse loading from the bank to the boot machine
    logic fuse_done;

    // SoC commands are buffered here and credits flow back from it
    fuse_intake #(
        .CREDITS    (CREDITS),
        .FUSE_WORDS (FUSE_WORDS)
    ) intake0 (
        .clk           (clk),
        .cptra_rst_b   (cptra_rst_b),
        .cmd_valid     (cmd_valid),
        .cmd_op        (cmd_op),
        .cmd_addr      (cmd_addr),
        .cmd_data      (cmd_data),
        .pop_valid     (pop_valid),
        .pop_op        (pop_op),
        .pop_addr      (pop_addr),
        .pop_data      (pop_data),
        .credit_return (credit_return)
    );

    // write-once fuse storage, gated by the boot machine's ready signal
    fuse_bank #(
        .FUSE_WORDS (FUSE_WORDS)
    ) bank0 (
        .clk             (clk),
        .cptra_rst_b     (cptra_rst_b),
        .ready_for_fuses (ready_for_fuses),
        .pop_valid       (pop_valid),
        .pop_op          (pop_op),
        .pop_addr        (pop_addr),
        .pop_data        (pop_data),
        .fuse_done       (fuse_done),
        .rd_addr         (rd_addr),
        .rd_data         (rd_data)
    );

    // boot sequencing and the microcontroller reset release
    boot_fsm fsm0 (
        .clk             (clk),
        .cptra_rst_b     (cptra_rst_b),
        .cptra_pwrgood   (cptra_pwrgood),
        .fuse_done       (fuse_done),
        .ready_for_fuses (ready_for_fuses),
        .uc_rst_b        (uc_rst_b)
    );

endmodule

`default_nettype wire

// ==== source/fuse_bank.sv ====
// write-once fuse registers; commands outside the fuse loading phase are dropped and no integrity check is made
`default_nettype none

module fuse_bank #(
    parameter int unsigned FUSE_WORDS = boot_pkg::DEFAULT_FUSE_WORDS
) (
    input  logic                                clk,
    input  logic                                cptra_rst_b,
    input  logic                                ready_for_fuses,
    input  logic                                pop_valid,
    input  boot_pkg::fuse_op_e                  pop_op,
    input  logic [$clog2(FUSE_WORDS)-1:0]       pop_addr,
    input  logic [boot_pkg::FUSE_DATA_W-1:0]    pop_data,
    output logic                                fuse_done,
    input  logic [$clog2(FUSE_WORDS)-1:0]       rd_addr,
    output logic [boot_pkg::FUSE_DATA_W-1:0]    rd_data
);

    // address width follows the number of fuse words
    localparam int unsigned ADDR_W = $clog2(FUSE_WORDS);

    // fuse values and the per word written flags
    logic [boot_pkg::FUSE_DATA_W-1:0] fuse_q [FUSE_WORDS];
    logic [FUSE_WORDS-1:0]            written_q;

    // one write enable per word after the write-once filter
    logic [FUSE_WORDS-1:0] word_we;

    // decoded commands that arrive while the boot machine is taking fuses
    logic accept;
    logic wr_cmd;
    logic done_cmd;

    // anything popped before power-good or after done is simply lost
    assign accept = pop_valid && ready_for_fuses;

    // split the accepted command by its opcode
    assign wr_cmd   = accept && (pop_op == boot_pkg::FUSE_OP_WRITE);
    assign done_cmd = accept && (pop_op == boot_pkg::FUSE_OP_DONE);

    // per word storage
    for (genvar w = 0; w < FUSE_WORDS; w++) begin : g_word
        // a word takes the write only while its flag is still clear
        assign word_we[w] = wr_cmd && (pop_addr == ADDR_W'(w)) && !written_q[w];

        // value and flag are updated together at the pop edge
        always_ff @(posedge clk or negedge cptra_rst_b) begin
            if (!cptra_rst_b) begin
                fuse_q[w]    <= '0;
                written_q[w] <= 1'b0;
            end else if (word_we[w]) begin
                fuse_q[w]    <= pop_data;
                // later writes to this word are ignored until the next reset
                written_q[w] <= 1'b1;
            end
        end
    end

    // the done flag is registered and sticky
    // it rises one cycle after the done command is popped
    always_ff @(posedge clk or negedge cptra_rst_b) begin
        if (!cptra_rst_b) begin
            fuse_done <= 1'b0;
        end else if (done_cmd) begin
            fuse_done <= 1'b1;
        end
    end

    // the microcontroller reads the array straight through with no latency
    // unwritten words read back as zero
    assign rd_data = fuse_q[rd_addr];

endmodule

`default_nettype wire

// ==== source/fuse_intake.sv ====
// credit based command queue; it relies on the sender never exceeding CREDITS outstanding commands
`default_nettype none

module fuse_intake #(
    parameter int unsigned CREDITS    = boot_pkg::DEFAULT_CREDITS,
    parameter int unsigned FUSE_WORDS = boot_pkg::DEFAULT_FUSE_WORDS
) (
    input  logic                                clk,
    input  logic                                cptra_rst_b,
    input  logic                                cmd_valid,
    input  boot_pkg::fuse_op_e                  cmd_op,
    input  logic [$clog2(FUSE_WORDS)-1:0]       cmd_addr,
    input  logic [boot_pkg::FUSE_DATA_W-1:0]    cmd_data,
    output logic                                pop_valid,
    output boot_pkg::fuse_op_e                  pop_op,
    output logic [$clog2(FUSE_WORDS)-1:0]       pop_addr,
    output logic [boot_pkg::FUSE_DATA_W-1:0]    pop_data,
    output logic                                credit_return
);

    // address width follows the size of the fuse bank
    localparam int unsigned ADDR_W = $clog2(FUSE_WORDS);

    // pointer width is kept at one bit or more so a single entry queue still builds
    localparam int unsigned PTR_W = (CREDITS > 1) ? $clog2(CREDITS) : 1;

    // the count has to reach CREDITS itself when the queue is full
    localparam int unsigned CNT_W = $clog2(CREDITS + 1);

    // circular queue storage, one field per command part
    boot_pkg::fuse_op_e               op_mem   [CREDITS];
    logic [ADDR_W-1:0]                addr_mem [CREDITS];
    logic [boot_pkg::FUSE_DATA_W-1:0] data_mem [CREDITS];

    // write and read pointers plus the number of held entries
    logic [PTR_W-1:0] wr_ptr_q;
    logic [PTR_W-1:0] rd_ptr_q;
    logic [CNT_W-1:0] count_q;

    // advance a pointer and wrap after the last entry
    // the explicit wrap also covers depths that are not a power of two
    function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
        logic [PTR_W-1:0] nxt;
        if (ptr == PTR_W'(CREDITS - 1)) begin
            nxt = '0;
        end else begin
            nxt = ptr + PTR_W'(1);
        end
        return nxt;
    endfunction

    // the head entry is offered whenever the queue holds anything
    // the bank takes it in the same cycle, so offering it is the pop
    assign pop_valid = (count_q != '0);
    assign pop_op    = op_mem[rd_ptr_q];
    assign pop_addr  = addr_mem[rd_ptr_q];
    assign pop_data  = data_mem[rd_ptr_q];

    // each accepted command lands in the slot at the write pointer
    always_ff @(posedge clk) begin
        if (cmd_valid) begin
            op_mem[wr_ptr_q]   <= cmd_op;
            addr_mem[wr_ptr_q] <= cmd_addr;
            data_mem[wr_ptr_q] <= cmd_data;
        end
    end

    // pointers, occupancy and the credit pulse
    always_ff @(posedge clk or negedge cptra_rst_b) begin
        if (!cptra_rst_b) begin
            wr_ptr_q      <= '0;
            rd_ptr_q      <= '0;
            count_q       <= '0;
            credit_return <= 1'b0;
        end else begin
            if (cmd_valid) begin
                wr_ptr_q <= ptr_inc(wr_ptr_q);
            end
            if (pop_valid) begin
                rd_ptr_q <= ptr_inc(rd_ptr_q);
            end
            // a push and a pop in the same cycle leave the count alone
            case ({cmd_valid, pop_valid})
                2'b10:   count_q <= count_q + CNT_W'(1);
                2'b01:   count_q <= count_q - CNT_W'(1);
                default: count_q <= count_q;
            endcase
            // one credit goes back in the cycle after every pop
            credit_return <= pop_valid;
        end
    end

endmodule

`default_nettype wire

// ==== source/boot_fsm.sv ====
// boot sequencer; assumes power-good is already synchronous to clk and never re-enters boot without reset
`default_nettype none

module boot_fsm (
    input  logic clk,
    input  logic cptra_rst_b,
    input  logic cptra_pwrgood,
    input  logic fuse_done,
    output logic ready_for_fuses,
    output logic uc_rst_b
);

    // present and next boot state
    boot_pkg::boot_fsm_state_e state_q;
    boot_pkg::boot_fsm_state_e state_d;

    // high for every cycle spent in the done state
    logic release_en;

    // sticky release flag that feeds the microcontroller reset flop
    logic release_q;

    // next state and the decoded state outputs
    always_comb begin
        state_d         = state_q;
        ready_for_fuses = 1'b0;
        release_en      = 1'b0;
        unique case (state_q)
            boot_pkg::BOOT_IDLE: begin
                // leave idle as soon as the SoC reports power good
                if (cptra_pwrgood) begin
                    state_d = boot_pkg::BOOT_FUSE;
                end
            end
            boot_pkg::BOOT_FUSE: begin
                // the fuse bank only accepts commands in this state
                ready_for_fuses = 1'b1;
                if (fuse_done) begin
                    state_d = boot_pkg::BOOT_DONE;
                end
            end
            boot_pkg::BOOT_DONE: begin
                // terminal until the next reset, so only the release is asserted here
                release_en = 1'b1;
            end
            default: begin
                // the spare encoding falls back to idle
                state_d = boot_pkg::BOOT_IDLE;
            end
        endcase
    end

    // state register and the two stage microcontroller reset release
    // uc_rst_b rises two edges after the machine enters the done state
    always_ff @(posedge clk or negedge cptra_rst_b) begin
        if (!cptra_rst_b) begin
            state_q   <= boot_pkg::BOOT_IDLE;
            release_q <= 1'b0;
            uc_rst_b  <= 1'b0;
        end else begin
            state_q <= state_d;
            // once set the release flag holds until reset
            if (release_en) begin
                release_q <= 1'b1;
            end
            // a plain flop stage so the reset output comes straight from a register
            uc_rst_b <= release_q;
        end
    end

endmodule

`default_nettype wire

// ==== source/boot_pkg.sv ====
// shared boot types and sizes; the fuse word is fixed at 32 bits and fuse counts must be powers of two
`default_nettype none

package boot_pkg;

    // width of one fuse word as sent by the SoC and read by the microcontroller
    localparam int unsigned FUSE_DATA_W = 32;

    // default size of the fuse register bank
    // the top level may override it but it has to stay a power of two of at least two
    localparam int unsigned DEFAULT_FUSE_WORDS = 16;

    // default depth of the intake queue
    // this is also the number of credits the SoC holds when it leaves reset
    localparam int unsigned DEFAULT_CREDITS = 4;

    // progress of the boot sequence
    // idle waits for power-good, fuse accepts fuse words, done releases the microcontroller
    // the unused code 2'b11 is treated as idle by the state machine
    typedef enum logic [1:0] {
        BOOT_IDLE = 2'b00,
        BOOT_FUSE = 2'b01,
        BOOT_DONE = 2'b10
    } boot_fsm_state_e;

    // opcode carried with every intake command
    // a write stores one fuse word, done closes the loading phase
    // for a done command the address and data fields are ignored
    typedef enum logic {
        FUSE_OP_WRITE = 1'b0,
        FUSE_OP_DONE  = 1'b1
    } fuse_op_e;

endpackage

`default_nettype wire
